/* design/axi_pkg.sv */
package axi_pkg;

	// *************************************************************************
	// Bus widths
	// *************************************************************************

	// Fixed for this subsystem, the structs below depend on them
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int id_w   = 4;

	// *************************************************************************
	// AR channel encodings
	// *************************************************************************

	// 4 bytes per beat, full data bus width
	localparam logic [2:0] axi_size_c = 3'b010;

	// Burst type codes
	localparam logic [1:0] burst_fixed_c = 2'b00;
	localparam logic [1:0] burst_incr_c  = 2'b01;

	// Read address request, 49 bits
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		// Beats minus one
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	// Read data beat
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [data_w-1:0] data;
		// Response code, not checked by the read engine
		logic [1:0]        resp;
		// Final beat of the burst
		logic              last;
	} axi_r_t;

endpackage

/* design/dma_pkg.sv */
package dma_pkg;

	// *************************************************************************
	// Transfer descriptor
	// *************************************************************************

	// Two-dimensional read job, handed over with the start strobe
	typedef struct packed {
		// Byte address of the first line
		logic [axi_pkg::addr_w-1:0] base;
		// Bytes per line, non-zero multiple of 4
		logic [15:0]                line_size;
		// Number of lines in the job
		logic [15:0]                num_lines;
		// Byte distance from one line start to the next
		logic [axi_pkg::addr_w-1:0] stride;
	} xfer_cfg_t;

	// *************************************************************************
	// Data buffer word
	// *************************************************************************

	// One R beat as seen by the consumer
	typedef struct packed {
		// Read data, passed on unchanged
		logic [axi_pkg::data_w-1:0] data;
		// Set on the final beat of each burst
		logic                       last;
	} buf_word_t;

endpackage

/* design/axi_ar_cmd_gen.sv */
`timescale 1ns/1ps

module axi_ar_cmd_gen #(
	parameter int MAX_BURST_LEN = 16
) (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic                       start,
	input  dma_pkg::xfer_cfg_t         cfg,
	input  logic                       ar_ready,
	output logic [axi_pkg::addr_w-1:0] ar_addr,
	output logic [7:0]                 ar_len,
	output logic                       ar_incr,
	output logic                       ar_valid,
	output logic                       busy
);
	import axi_pkg::*;

	// Burst length cap in beats, same width as the beat math below
	localparam logic [13:0] max_beats_c = 14'(MAX_BURST_LEN);

	// Job in progress, drives both ar_valid and busy
	logic              active;
	// Descriptor fields needed after start
	logic [15:0]       line_size_q;
	logic [addr_w-1:0] stride_q;
	// Walk state
	logic [addr_w-1:0] line_base;
	logic [addr_w-1:0] cur_addr;
	logic [15:0]       rem_bytes;
	logic [15:0]       lines_left;
	// Burst sizing
	logic [12:0]       page_bytes;
	logic [13:0]       beats;
	logic [15:0]       burst_bytes;
	// Events
	logic              start_ok;
	logic              ar_fire;
	logic              line_end;
	logic              xfer_end;

	// *************************************************************************
	// Burst sizing
	// *************************************************************************

	// Bytes left before the next 4 KB page, 4 to 4096
	assign page_bytes = 13'h1000 - {1'b0, cur_addr[11:0]};

	// Smallest of line remainder, length cap and page remainder
	always_comb begin
		beats = rem_bytes[15:2];
		if (beats > max_beats_c) begin
			beats = max_beats_c;
		end
		if (beats > {3'b000, page_bytes[12:2]}) begin
			beats = {3'b000, page_bytes[12:2]};
		end
	end

	assign burst_bytes = {beats, 2'b00};

	// This burst finishes the line, and maybe the whole job
	assign line_end = (burst_bytes == rem_bytes);
	assign xfer_end = line_end && (lines_left == 16'd1);

	// A zero-line job has nothing to fetch, so it is dropped
	assign start_ok = start && !active && (cfg.num_lines != 16'd0);
	assign ar_fire  = active && ar_ready;

	// *************************************************************************
	// Control state
	// *************************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active     <= 1'b0;
			lines_left <= '0;
			rem_bytes  <= '0;
		end else if (start_ok) begin
			active     <= 1'b1;
			lines_left <= cfg.num_lines;
			rem_bytes  <= cfg.line_size;
		end else if (ar_fire) begin
			// Last request of the job, drop busy next cycle
			if (xfer_end) begin
				active <= 1'b0;
			end
			if (line_end) begin
				lines_left <= lines_left - 16'd1;
				rem_bytes  <= line_size_q;
			end else begin
				rem_bytes <= rem_bytes - burst_bytes;
			end
		end
	end

	// Address path, only meaningful while active
	always_ff @(posedge clk) begin
		if (start_ok) begin
			line_size_q <= cfg.line_size;
			stride_q    <= cfg.stride;
			line_base   <= cfg.base;
			cur_addr    <= cfg.base;
		end else if (ar_fire) begin
			if (line_end) begin
				// Jump to the start of the next line
				line_base <= line_base + stride_q;
				cur_addr  <= line_base + stride_q;
			end else begin
				cur_addr <= cur_addr + addr_w'(burst_bytes);
			end
		end
	end

	// *************************************************************************
	// Outputs
	// *************************************************************************

	assign ar_addr  = cur_addr;
	assign ar_len   = 8'(beats - 14'd1);
	assign ar_incr  = (beats != 14'd1);
	assign ar_valid = active;
	assign busy     = active;

	// Request must not change while the slave stalls it
	ap_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len));

	// No burst runs past a 4 KB page
	ap_no_4k_cross: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid |-> (14'(ar_addr[11:0]) + {4'd0, ar_len, 2'b00} + 14'd4) <= 14'd4096);

	// Length field stays within the configured cap
	ap_len_max: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid |-> int'(ar_len) < MAX_BURST_LEN);

endmodule

/* design/axi_rd_dma.sv */
`timescale 1ns/1ps

module axi_rd_dma #(
	parameter int MAX_BURST_LEN = 16
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  dma_pkg::xfer_cfg_t cfg,
	output logic               busy,
	output axi_pkg::axi_ar_t   ar,
	output logic               ar_valid,
	input  logic               ar_ready,
	input  axi_pkg::axi_r_t    r,
	input  logic               r_valid,
	output logic               r_ready,
	output dma_pkg::buf_word_t word,
	output logic               word_valid,
	input  logic               word_ready
);
	import axi_pkg::*;

	// Raw burst request from the generator
	logic [addr_w-1:0] gen_addr;
	logic [7:0]        gen_len;
	logic              gen_incr;

	// *************************************************************************
	// AR channel
	// *************************************************************************

	axi_ar_cmd_gen #(
		.MAX_BURST_LEN(MAX_BURST_LEN)
	) i_cmd_gen (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (start),
		.cfg     (cfg),
		.ar_ready(ar_ready),
		.ar_addr (gen_addr),
		.ar_len  (gen_len),
		.ar_incr (gen_incr),
		.ar_valid(ar_valid),
		.busy    (busy)
	);

	// Single ID, full-width beats; single-beat bursts go out as FIXED
	assign ar = '{
		id:    '0,
		addr:  gen_addr,
		len:   gen_len,
		size:  axi_size_c,
		burst: gen_incr ? burst_incr_c : burst_fixed_c
	};

	// *************************************************************************
	// R channel to data buffer
	// *************************************************************************

	// Straight mapping, zero latency; RRESP and RID are ignored
	assign word       = '{data: r.data, last: r.last};
	assign word_valid = r_valid;
	// Buffer back-pressure goes right back to the slave
	assign r_ready    = word_ready;

	// Slave keeps its beat up until it is taken
	ap_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
		r_valid && !r_ready |=> r_valid && $stable(r));

endmodule

/* design/stream_fifo.sv */
`timescale 1ns/1ps

module stream_fifo #(
	parameter type payload_t  = logic,
	parameter int  FIFO_DEPTH = 8
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t in_data,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out_data,
	output logic     out_valid,
	input  logic     out_ready
);
	// Depth is a power of two, so pointers wrap on their own
	localparam int              ptr_w   = $clog2(FIFO_DEPTH);
	localparam logic [ptr_w:0] depth_c = (ptr_w + 1)'(FIFO_DEPTH);

	// Storage
	payload_t         mem [FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	// Occupancy from 0 to FIFO_DEPTH
	logic [ptr_w:0]   count;
	logic             push;
	logic             pop;

	// *************************************************************************
	// Handshakes
	// *************************************************************************

	assign in_ready  = (count != depth_c);
	assign out_valid = (count != '0);
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// Head of queue is readable one cycle after the write
	assign out_data = mem[rd_ptr];

	// *************************************************************************
	// Storage and pointers
	// *************************************************************************

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Occupancy never goes past the depth
	ap_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		count <= depth_c);

	// Nothing leaves an empty queue, so its count never wraps below zero
	ap_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		count == '0 && !push |=> count == '0);

	// count agrees with the pointer distance
	ap_ptr_count: assert property (@(posedge clk) disable iff (!arst_n)
		count[ptr_w-1:0] == ptr_w'(wr_ptr - rd_ptr));

endmodule

/* design/axi_rd_subsys.sv */
`timescale 1ns/1ps

module axi_rd_subsys #(
	parameter int MAX_BURST_LEN = 16,
	parameter int FIFO_DEPTH    = 8
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               start,
	input  dma_pkg::xfer_cfg_t cfg,
	output logic               busy,
	output axi_pkg::axi_ar_t   ar,
	output logic               ar_valid,
	input  logic               ar_ready,
	input  axi_pkg::axi_r_t    r,
	input  logic               r_valid,
	output logic               r_ready,
	output dma_pkg::buf_word_t out_word,
	output logic               out_valid,
	input  logic               out_ready
);
	import dma_pkg::*;

	// Read engine to output queue
	buf_word_t word;
	logic      word_valid;
	logic      word_ready;

	// Read engine, owns AR and R
	axi_rd_dma #(
		.MAX_BURST_LEN(MAX_BURST_LEN)
	) i_rd_dma (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.cfg       (cfg),
		.busy      (busy),
		.ar        (ar),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r         (r),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.word      (word),
		.word_valid(word_valid),
		.word_ready(word_ready)
	);

	// Output queue decouples R from the consumer
	stream_fifo #(
		.payload_t (buf_word_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_out_fifo (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_data  (word),
		.in_valid (word_valid),
		.in_ready (word_ready),
		.out_data (out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

/* sim/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
	output logic clk,
	output logic arst_n
);
	// 8 ns period
	localparam int half_period_c  = 4;
	localparam int reset_cycles_c = 3;

	initial begin
		clk = 1'b0;
		forever #(half_period_c) clk = ~clk;
	end

	// Reset low over the first rising edges, released on an edge
	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles_c) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

/* sim/axi_rd_slave_model.sv */
`timescale 1ns/1ps

module axi_rd_slave_model (
	input  logic             clk,
	input  logic             arst_n,
	input  axi_pkg::axi_ar_t ar,
	input  logic             ar_valid,
	output logic             ar_ready,
	output axi_pkg::axi_r_t  r,
	output logic             r_valid,
	input  logic             r_ready
);
	import axi_pkg::*;

	localparam logic [1:0] resp_okay_c = 2'b00;

	// Accepted requests still waiting for their data
	axi_ar_t           pending [$];
	// Burst being returned right now
	axi_ar_t           req;
	logic [addr_w-1:0] beat_addr;
	int                beats_left;

	initial begin
		ar_ready   = 1'b0;
		r_valid    = 1'b0;
		r          = '0;
		req        = '0;
		beat_addr  = '0;
		beats_left = 0;
		forever begin
			@(posedge clk);
			if (!arst_n) begin
				ar_ready <= 1'b0;
				r_valid  <= 1'b0;
				pending.delete();
				beats_left = 0;
			end else begin
				// *********************************************************************
				// AR side
				// *********************************************************************
				if (ar_valid && ar_ready) begin
					pending.push_back(ar);
				end
				// Random stalls, ready about three cycles in four
				ar_ready <= ($urandom_range(0, 3) != 0);

				// *********************************************************************
				// R side
				// *********************************************************************
				// Beat stays put until the DUT takes it
				if (!r_valid || r_ready) begin
					if (beats_left == 0 && pending.size() > 0) begin
						req        = pending.pop_front();
						beat_addr  = req.addr;
						beats_left = int'(req.len) + 1;
					end
					// Random gaps between beats
					if (beats_left > 0 && $urandom_range(0, 3) != 0) begin
						r_valid <= 1'b1;
						// Data is the byte address of the beat
						r <= '{
							id:   '0,
							data: beat_addr,
							resp: resp_okay_c,
							last: (beats_left == 1)
						};
						beat_addr  = beat_addr + 32'd4;
						beats_left = beats_left - 1;
					end else begin
						r_valid <= 1'b0;
					end
				end
			end
		end
	end

endmodule

/* sim/tb_axi_rd_subsys.sv */
`timescale 1ns/1ps

module tb_axi_rd_subsys;
	import axi_pkg::*;
	import dma_pkg::*;

	localparam int max_burst_len = 16;
	localparam int fifo_depth    = 8;
	localparam int num_jobs      = 10;

	logic      clk;
	logic      arst_n;
	logic      start;
	xfer_cfg_t cfg;
	logic      busy;
	axi_ar_t   ar;
	logic      ar_valid;
	logic      ar_ready;
	axi_r_t    r;
	logic      r_valid;
	logic      r_ready;
	buf_word_t out_word;
	logic      out_valid;
	logic      out_ready;

	// Expected traffic from the reference model
	axi_ar_t   ar_q [$];
	buf_word_t wq [$];
	// Heads of the queues as seen at the next edge
	axi_ar_t   exp_ar;
	buf_word_t exp_word;
	logic      have_ar;
	logic      final_ar;
	logic      have_word;
	// Words inside the output FIFO
	int        fifo_cnt;
	int        words_seen;
	int        errors = 0;
	int        timeout_cycles = 0;
	xfer_cfg_t jobs [num_jobs];

	clk_gen clk_gen0 (
		.clk   (clk),
		.arst_n(arst_n)
	);

	axi_rd_subsys #(
		.MAX_BURST_LEN(max_burst_len),
		.FIFO_DEPTH   (fifo_depth)
	) dut0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.start    (start),
		.cfg      (cfg),
		.busy     (busy),
		.ar       (ar),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready),
		.r        (r),
		.r_valid  (r_valid),
		.r_ready  (r_ready),
		.out_word (out_word),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	axi_rd_slave_model slave0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.ar      (ar),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.r       (r),
		.r_valid (r_valid),
		.r_ready (r_ready)
	);

	task automatic report_mismatch(input string name, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		errors++;
		$display("error %s: expected %0h, actual %0h", name, exp_val, act_val);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Failure: %s", what);
	endtask

	// *************************************************************************
	// Reference model
	// *************************************************************************

	// Cut each line at its end, at the burst cap or at a 4 KB page
	task automatic expand_job(input xfer_cfg_t c);
		logic [31:0] addr;
		int          rem;
		int          chunk;
		int          page;
		for (int k = 0; k < int'(c.num_lines); k++) begin
			addr = c.base + c.stride * 32'(k);
			rem  = int'(c.line_size);
			while (rem > 0) begin
				page  = 4096 - int'(addr[11:0]);
				chunk = rem;
				if (chunk > max_burst_len * 4) begin
					chunk = max_burst_len * 4;
				end
				if (chunk > page) begin
					chunk = page;
				end
				ar_q.push_back('{
					id:    '0,
					addr:  addr,
					len:   8'(chunk / 4 - 1),
					size:  axi_size_c,
					burst: (chunk == 4) ? burst_fixed_c : burst_incr_c
				});
				for (int b = 0; b < chunk / 4; b++) begin
					wq.push_back('{data: addr + 32'(4 * b), last: (b == chunk / 4 - 1)});
				end
				addr = addr + 32'(chunk);
				rem  = rem - chunk;
			end
		end
	endtask

	// AR expectation pointer
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			have_ar  <= 1'b0;
			final_ar <= 1'b0;
			exp_ar   <= '0;
		end else begin
			if (ar_valid && ar_ready && ar_q.size() > 0) begin
				void'(ar_q.pop_front());
			end
			have_ar  <= (ar_q.size() > 0);
			final_ar <= (ar_q.size() == 1);
			if (ar_q.size() > 0) begin
				exp_ar <= ar_q[0];
			end
		end
	end

	// Output word pointer and FIFO fill level
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			have_word  <= 1'b0;
			exp_word   <= '0;
			fifo_cnt   <= 0;
			words_seen <= 0;
		end else begin
			if (out_valid && out_ready && wq.size() > 0) begin
				void'(wq.pop_front());
			end
			have_word <= (wq.size() > 0);
			if (wq.size() > 0) begin
				exp_word <= wq[0];
			end
			fifo_cnt <= fifo_cnt + int'(r_valid && r_ready) - int'(out_valid && out_ready);
			if (out_valid && out_ready) begin
				words_seen <= words_seen + 1;
			end
		end
	end

	// *************************************************************************
	// Checks
	// *************************************************************************

	// Burst address and length
	ap_ar_addr: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid && ar_ready |-> ar.addr == exp_ar.addr)
		else report_mismatch("ar_addr", $sampled(exp_ar.addr), $sampled(ar.addr));
	ap_ar_len: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid && ar_ready |-> ar.len == exp_ar.len)
		else report_mismatch("ar_len", 32'($sampled(exp_ar.len)), 32'($sampled(ar.len)));
	ap_ar_pending: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid |-> have_ar)
		else note_failure("AR request issued while no burst was expected");

	// FIXED only for single beats, 4-byte size, ID zero
	ap_ar_burst: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid && ar_ready |-> ar.burst == exp_ar.burst)
		else report_mismatch("ar_burst", 32'($sampled(exp_ar.burst)),
			32'($sampled(ar.burst)));
	ap_ar_size: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid |-> ar.size == axi_size_c)
		else report_mismatch("ar_size", 32'(axi_size_c), 32'($sampled(ar.size)));
	ap_ar_id: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid |-> ar.id == '0)
		else report_mismatch("ar_id", 32'd0, 32'($sampled(ar.id)));

	// Output words arrive in order with nothing lost or repeated
	ap_word_data: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> out_word.data == exp_word.data)
		else report_mismatch("word_data", $sampled(exp_word.data), $sampled(out_word.data));
	ap_word_last: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> out_word.last == exp_word.last)
		else report_mismatch("word_last", 32'($sampled(exp_word.last)),
			32'($sampled(out_word.last)));
	ap_word_pending: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && out_ready |-> have_word)
		else note_failure("output word accepted while none was expected");

	// Back-pressure and stream stability
	ap_full_stall: assert property (@(posedge clk) disable iff (!arst_n)
		fifo_cnt == fifo_depth |-> !r_ready)
		else note_failure("r_ready high while the output FIFO is full");
	ap_fill_latency: assert property (@(posedge clk) disable iff (!arst_n)
		r_valid && r_ready && fifo_cnt == 0 |=> out_valid)
		else note_failure("word into empty FIFO not visible one cycle later");
	ap_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_word))
		else note_failure("out_word changed or dropped while stalled");

	// Reset state and busy timing
	ap_reset_idle: assert property (@(posedge clk)
		!arst_n |-> !busy && !ar_valid && !out_valid)
		else note_failure("busy, ar_valid or out_valid high during reset");
	ap_busy_rise: assert property (@(posedge clk) disable iff (!arst_n)
		start && !busy |=> busy)
		else note_failure("busy did not rise the cycle after start");
	ap_busy_idle: assert property (@(posedge clk) disable iff (!arst_n)
		!busy && !start |=> !busy)
		else note_failure("busy rose without a start");
	ap_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
		ar_valid && ar_ready && final_ar |=> !busy)
		else note_failure("busy still high after the final AR handshake");
	ap_busy_hold: assert property (@(posedge clk) disable iff (!arst_n)
		busy && !(ar_valid && ar_ready && final_ar) |=> busy)
		else note_failure("busy fell before the final AR handshake");

	// *************************************************************************
	// Stimulus
	// *************************************************************************

	// Consumer stalls at random
	initial begin
		out_ready = 1'b0;
		forever begin
			@(posedge clk);
			out_ready <= arst_n && ($urandom_range(0, 9) < 6);
		end
	end

	initial begin
		int total;
		int first;
		int expected;
		void'($urandom(66101));
		start = 1'b0;
		cfg   = '0;
		total = 0;
		@(posedge clk);
		while (!arst_n) begin
			@(posedge clk);
		end
		// Job 0 crosses 4 KB on every line and job 1 has single-beat lines
		jobs[0] = '{base: 32'h0000_0FE8, line_size: 16'd96, num_lines: 16'd3,
			stride: 32'h0000_1000};
		jobs[1] = '{base: 32'h0000_2004, line_size: 16'd4, num_lines: 16'd6,
			stride: 32'h0000_0010};
		for (int i = 2; i < num_jobs; i++) begin
			jobs[i].base      = $urandom & 32'h000F_FFFC;
			jobs[i].line_size = 16'(4 * $urandom_range(1, 48));
			jobs[i].num_lines = 16'($urandom_range(1, 4));
			jobs[i].stride    = 32'(jobs[i].line_size) + 32'(4 * $urandom_range(0, 300));
		end
		foreach (jobs[i]) begin
			total += int'(jobs[i].line_size) / 4 * int'(jobs[i].num_lines);
		end
		timeout_cycles = 200 * total + 2000;

		foreach (jobs[i]) begin
			expected = int'(jobs[i].line_size) / 4 * int'(jobs[i].num_lines);
			expand_job(jobs[i]);
			first = words_seen;
			@(posedge clk);
			start <= 1'b1;
			cfg   <= jobs[i];
			@(posedge clk);
			start <= 1'b0;
			repeat (2) @(posedge clk);
			// Second start lands while still busy, so it must be dropped
			if (busy && !(ar_valid && ar_ready && final_ar)) begin
				start <= 1'b1;
				cfg   <= jobs[(i + 1) % num_jobs];
				@(posedge clk);
				start <= 1'b0;
			end
			while (busy) begin
				@(posedge clk);
			end
			while (wq.size() != 0) begin
				@(posedge clk);
			end
			@(posedge clk);
			a_word_total: assert (words_seen - first == expected)
				else report_mismatch("word_total", 32'(expected), 32'(words_seen - first));
		end

		repeat (5) @(posedge clk);
		a_queues_empty: assert (ar_q.size() == 0 && wq.size() == 0)
			else note_failure("expected bursts or words never arrived");
		$display("Summary: %0d jobs, %0d words, %0d errors", num_jobs, words_seen, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog limit scales with the expected beat count
	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		$display("Timeout: run stopped after %0d cycles, %0d errors", timeout_cycles, errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

/* build.f */
design/axi_pkg.sv
design/dma_pkg.sv
design/axi_ar_cmd_gen.sv
design/axi_rd_dma.sv
design/stream_fifo.sv
design/axi_rd_subsys.sv
sim/clk_gen.sv
sim/axi_rd_slave_model.sv
sim/tb_axi_rd_subsys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_axi_rd_subsys
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Done: no errors

# Sources taken from the file list, include lines skipped
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
